// ==== rtl/gat_pkg.sv ====
`default_nettype none

package gat_pkg;

  // one WH row holds four projected features
  localparam int num_feature_out = 4;
  localparam int wh_data_width   = 8;

  // attention coefficient is unsigned Q0.8
  localparam int alpha_width = 8;

  // neighbor count field of the first row in a group
  localparam int num_node_width = 6;

  // features, neighbor count, source flag
  localparam int wh_width = num_feature_out * wh_data_width + num_node_width + 1;

  localparam int wh_addr_w      = 8;
  localparam int feature_addr_w = 8;

  // 16-bit product plus headroom for up to 63 neighbors
  localparam int acc_width = 23;

  // drops the Q0.8 fraction of the coefficient
  localparam int alpha_frac = 8;

  // finished vectors that may wait for the feature memory
  localparam int pend_depth = 3;

  typedef logic signed [num_feature_out-1:0][wh_data_width-1:0] feature_vec_t;

  // src_flag sits in the lowest bit of the memory word
  typedef struct packed {
    feature_vec_t              feat;
    logic [num_node_width-1:0] num_nodes;
    logic                      src_flag;
  } wh_row_t;

endpackage

`default_nettype wire

// ==== rtl/wh_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface wh_stream_if import gat_pkg::*; ();

  logic         valid;
  feature_vec_t feat;
  // first row of a group, carries the source flag
  logic         first;
  // row that closes the group
  logic         last;

  modport src (
    output valid, feat, first, last
  );

  modport dst (
    input valid, feat, first, last
  );

endinterface

`default_nettype wire

// ==== rtl/wh_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module wh_fetch import gat_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pop,
  output logic [wh_addr_w-1:0] wh_addr,
  input  logic [wh_width-1:0]  wh_rd_data,
  wh_stream_if.src             row
);

  logic [wh_addr_w-1:0]      addr_q;
  logic                      rd_valid_q;
  wh_row_t                   rd_row;
  logic [num_node_width-1:0] remain_q;
  logic [num_node_width-1:0] remain_next;

  // address of the row being read in the pop cycle
  assign wh_addr = addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pop) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // memory answers one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= pop;
    end
  end

  assign rd_row = wh_rd_data;

  // rows still to come in this group once the current one is taken
  always_comb begin
    if (rd_row.src_flag) begin
      remain_next = rd_row.num_nodes - 1'b1;
    end else begin
      remain_next = remain_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain_q <= '0;
    end else if (rd_valid_q) begin
      remain_q <= remain_next;
    end
  end

  assign row.valid = rd_valid_q;
  assign row.feat  = rd_row.feat;
  assign row.first = rd_valid_q && rd_row.src_flag;
  // a group of one is first and last at once
  assign row.last  = rd_valid_q && (remain_next == '0);

endmodule

`default_nettype wire

// ==== rtl/alpha_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module alpha_fetch import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic                   alpha_empty,
  input  logic [alpha_width-1:0] alpha_dout,
  output logic                   alpha_rd,
  output logic                   pop,
  output logic                   alpha_valid,
  output logic [alpha_width-1:0] alpha
);

  logic run_q;

  // reads start the cycle after reset releases
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // FWFT data is valid whenever the FIFO is not empty
  assign alpha_rd = run_q && !alpha_empty && !stall;

  // each coefficient pop also advances the WH row
  assign pop = alpha_rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alpha_valid <= 1'b0;
    end else begin
      alpha_valid <= alpha_rd;
    end
  end

  // held one cycle so it meets the WH row
  always_ff @(posedge clk) begin
    if (alpha_rd) begin
      alpha <= alpha_dout;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/neighbor_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

module neighbor_mac import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  wh_stream_if.dst               row,
  input  logic                   alpha_valid,
  input  logic [alpha_width-1:0] alpha,
  output logic                   vec_valid,
  output feature_vec_t           vec
);

  logic                        mac_en;
  logic signed [acc_width-1:0] product  [num_feature_out];
  logic signed [acc_width-1:0] acc_next [num_feature_out];
  logic signed [acc_width-1:0] acc_q    [num_feature_out];

  // scale back to integer, then clip to 0..127
  function automatic logic [wh_data_width-1:0] clip_feature(
    input logic signed [acc_width-1:0] sum
  );
    logic signed [acc_width-1:0] scaled;
    scaled = sum >>> alpha_frac;
    if (scaled < 0) begin
      clip_feature = '0;
    end else if (scaled > (2 ** (wh_data_width - 1)) - 1) begin
      clip_feature = wh_data_width'((2 ** (wh_data_width - 1)) - 1);
    end else begin
      clip_feature = scaled[wh_data_width-1:0];
    end
  endfunction

  assign mac_en = row.valid && alpha_valid;

  // signed feature times unsigned coefficient, one multiplier per lane
  always_comb begin
    for (int i = 0; i < num_feature_out; i++) begin
      product[i] = $signed(row.feat[i]) * $signed({1'b0, alpha});
    end
  end

  // the first row of a group restarts the sum
  always_comb begin
    for (int i = 0; i < num_feature_out; i++) begin
      if (row.first) begin
        acc_next[i] = product[i];
      end else begin
        acc_next[i] = acc_q[i] + product[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mac_en) begin
      for (int i = 0; i < num_feature_out; i++) begin
        acc_q[i] <= acc_next[i];
      end
    end
  end

  // vector leaves one cycle after the last row of the group
  always_ff @(posedge clk) begin
    if (mac_en && row.last) begin
      for (int i = 0; i < num_feature_out; i++) begin
        vec[i] <= clip_feature(acc_next[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_valid <= 1'b0;
    end else begin
      vec_valid <= mac_en && row.last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/feature_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_writer import gat_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      vec_valid,
  input  feature_vec_t              vec,
  output logic                      stall,
  output logic                      idle,
  output logic [feature_addr_w-1:0] feature_addr,
  output logic [wh_data_width-1:0]  feature_din,
  output logic                      feature_ena
);

  feature_vec_t                         queue_q [pend_depth];
  logic [$clog2(pend_depth)-1:0]        wr_ptr_q;
  logic [$clog2(pend_depth)-1:0]        rd_ptr_q;
  logic [$clog2(pend_depth+1)-1:0]      count_q;
  logic [$clog2(num_feature_out)-1:0]   word_q;
  logic [feature_addr_w-1:0]            addr_q;
  logic                                 busy;
  logic                                 last_word;

  // the head vector is written while anything is queued
  assign busy      = (count_q != '0);
  assign last_word = busy && (word_q == num_feature_out - 1);

  always_ff @(posedge clk) begin
    if (vec_valid) begin
      queue_q[wr_ptr_q] <= vec;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (vec_valid) begin
        wr_ptr_q <= (wr_ptr_q == pend_depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      // head retires with its last word
      if (last_word) begin
        rd_ptr_q <= (rd_ptr_q == pend_depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({vec_valid, last_word})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // lane 0 goes out first and the address keeps running across vectors
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_q <= '0;
      addr_q <= '0;
    end else if (busy) begin
      word_q <= last_word ? '0 : word_q + 1'b1;
      addr_q <= addr_q + 1'b1;
    end
  end

  assign feature_addr = addr_q;
  assign feature_din  = queue_q[rd_ptr_q][word_q];
  assign feature_ena  = busy;

  // holds coefficient pops while results wait
  assign stall = busy;
  assign idle  = (count_q == '0) && (word_q == '0);

endmodule

`default_nettype wire

// ==== rtl/gat_aggregator.sv ====
`timescale 1ns/10ps
`default_nettype none

module gat_aggregator import gat_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  // WH memory, synchronous read
  output logic [wh_addr_w-1:0]      wh_addr,
  input  logic [wh_width-1:0]       wh_rd_data,

  // coefficient FIFO, first word fall through
  input  logic [alpha_width-1:0]    alpha_dout,
  input  logic                      alpha_empty,
  output logic                      alpha_rd,

  // feature memory write port
  output logic [feature_addr_w-1:0] feature_addr,
  output logic [wh_data_width-1:0]  feature_din,
  output logic                      feature_ena,

  output logic                      idle
);

  logic                   pop;
  logic                   alpha_valid;
  logic [alpha_width-1:0] alpha;
  logic                   vec_valid;
  feature_vec_t           vec;
  logic                   stall;

  wh_stream_if row_if ();

  wh_fetch wh_fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop        (pop),
    .wh_addr    (wh_addr),
    .wh_rd_data (wh_rd_data),
    .row        (row_if.src)
  );

  alpha_fetch alpha_fetch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .alpha_empty (alpha_empty),
    .alpha_dout  (alpha_dout),
    .alpha_rd    (alpha_rd),
    .pop         (pop),
    .alpha_valid (alpha_valid),
    .alpha       (alpha)
  );

  neighbor_mac neighbor_mac_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .row         (row_if.dst),
    .alpha_valid (alpha_valid),
    .alpha       (alpha),
    .vec_valid   (vec_valid),
    .vec         (vec)
  );

  feature_writer feature_writer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .vec_valid    (vec_valid),
    .vec          (vec),
    .stall        (stall),
    .idle         (idle),
    .feature_addr (feature_addr),
    .feature_din  (feature_din),
    .feature_ena  (feature_ena)
  );

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // released just after the tenth rising edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/aggr_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module aggr_sva import gat_pkg::*; (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      alpha_rd,
  input logic                      alpha_empty,
  input logic                      stall,
  input logic                      feature_ena,
  input logic [feature_addr_w-1:0] feature_addr,
  input logic                      idle
);

  logic [1:0]                run_words;
  logic [feature_addr_w-1:0] last_addr;
  logic                      wrote_once;
  // number of failed assertions so far
  int                        fail_count = 0;

  // word position inside the vector being written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_words  <= '0;
      last_addr  <= '0;
      wrote_once <= 1'b0;
    end else if (feature_ena) begin
      run_words  <= run_words + 1'b1;
      last_addr  <= feature_addr;
      wrote_once <= 1'b1;
    end
  end

  no_read_when_blocked: assert property (
    @(posedge clk) disable iff (!rst_n) alpha_rd |-> (!alpha_empty && !stall)
  ) else begin
    $error("coefficient read while the FIFO is empty or the writer stalls");
    fail_count++;
  end

  // bursts end only on a vector boundary
  whole_vectors: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(feature_ena) |-> (run_words == 2'd0)
  ) else begin
    $error("feature write burst is not made of whole four word vectors");
    fail_count++;
  end

  addr_steps: assert property (
    @(posedge clk) disable iff (!rst_n)
    (feature_ena && wrote_once) |-> (feature_addr == feature_addr_w'(last_addr + 1'b1))
  ) else begin
    $error("feature address did not advance by one between writes");
    fail_count++;
  end

  reset_outputs: assert property (
    @(posedge clk) !rst_n |-> (!alpha_rd && !feature_ena && idle)
  ) else begin
    $error("outputs not in their reset state while reset is held");
    fail_count++;
  end

endmodule

bind gat_aggregator aggr_sva aggr_sva_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .alpha_rd     (alpha_rd),
  .alpha_empty  (alpha_empty),
  .stall        (stall),
  .feature_ena  (feature_ena),
  .feature_addr (feature_addr),
  .idle         (idle)
);

`default_nettype wire

// ==== test/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top import gat_pkg::*; ();

  // worst case rows of the five value tests
  localparam int max_rows    = 16 + 8 * 20 + 4 * 8 + 40 * 2 + 10 * 10;
  localparam int cycle_limit = max_rows * 8 + 1000;

  logic                      clk;
  logic                      rst_n;
  logic [wh_addr_w-1:0]      wh_addr;
  logic [wh_width-1:0]       wh_rd_data;
  logic [alpha_width-1:0]    alpha_dout;
  logic                      alpha_empty;
  logic                      alpha_rd;
  logic [feature_addr_w-1:0] feature_addr;
  logic [wh_data_width-1:0]  feature_din;
  logic                      feature_ena;
  logic                      idle;

  logic [wh_width-1:0]                     wh_mem [2**wh_addr_w];
  logic [alpha_width-1:0]                  alpha_q [$];
  // expected writes as {address, data}
  logic [feature_addr_w+wh_data_width-1:0] exp_q [$];
  logic [wh_addr_w-1:0]                    fill_addr;
  logic [feature_addr_w-1:0]               exp_addr;
  logic                                    gap_mode;
  string                                   test_name;
  int cycles    = 0;
  int checks    = 0;
  int errors    = 0;
  int tests_run = 0;

  clk_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_aggregator gat_aggregator_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_addr      (wh_addr),
    .wh_rd_data   (wh_rd_data),
    .alpha_dout   (alpha_dout),
    .alpha_empty  (alpha_empty),
    .alpha_rd     (alpha_rd),
    .feature_addr (feature_addr),
    .feature_din  (feature_din),
    .feature_ena  (feature_ena),
    .idle         (idle)
  );

  // WH memory with one cycle read latency
  always @(posedge clk) begin
    logic [wh_width-1:0] rd;
    rd = wh_mem[wh_addr];
    #2;
    wh_rd_data = rd;
  end

  // FWFT coefficient FIFO
  // in gap mode the head is hidden at random
  always @(posedge clk) begin
    if (alpha_rd && alpha_q.size() != 0) begin
      alpha_q.delete(0);
    end
    #2;
    alpha_dout  = (alpha_q.size() != 0) ? alpha_q[0] : '0;
    alpha_empty = (alpha_q.size() == 0) || (gap_mode && ($urandom_range(2, 0) == 0));
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d writes outstanding", cycles, exp_q.size());
      $display("test failed");
      $finish;
    end
  end

  // every write is compared with the next expected word
  always @(negedge clk) begin
    logic [feature_addr_w+wh_data_width-1:0] exp_word;
    if (rst_n && feature_ena) begin
      if (exp_q.size() == 0) begin
        $display("%s: write to address %0d with no result outstanding", test_name, feature_addr);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        checks++;
        assert ({feature_addr, feature_din} == exp_word) else begin
          $display("[FAIL] %s: expected addr %0d data %0d, actual addr %0d data %0d",
                   test_name, exp_word[feature_addr_w+wh_data_width-1:wh_data_width],
                   exp_word[wh_data_width-1:0], feature_addr, feature_din);
          errors++;
        end
      end
    end
  end

  // value check errors plus protocol assertion failures
  function automatic int error_total();
    return errors + gat_aggregator_i.aggr_sva_i.fail_count;
  endfunction

  // drop the fraction, then clip to 0..127
  function automatic logic [wh_data_width-1:0] expected_feature(input int sum);
    if (sum < 0) begin
      return '0;
    end
    if (sum >= (128 << alpha_frac)) begin
      return 8'd127;
    end
    return wh_data_width'(sum >> alpha_frac);
  endfunction

  // kind 1 drives lanes 0 and 1 far positive and lanes 2 and 3 far negative
  task automatic add_group(input int n, input int kind);
    int      sum [num_feature_out];
    wh_row_t r;
    int      f;
    int      a;
    for (int lane = 0; lane < num_feature_out; lane++) begin
      sum[lane] = 0;
    end
    for (int k = 0; k < n; k++) begin
      a = (kind == 1) ? int'($urandom_range(255, 200)) : int'($urandom_range(255, 0));
      r.src_flag  = (k == 0);
      r.num_nodes = (k == 0) ? num_node_width'(n) : num_node_width'($urandom);
      for (int lane = 0; lane < num_feature_out; lane++) begin
        if (kind == 0) begin
          f = int'($urandom_range(255, 0)) - 128;
        end else if (lane < 2) begin
          f = int'($urandom_range(127, 100));
        end else begin
          f = -int'($urandom_range(128, 100));
        end
        r.feat[lane] = wh_data_width'(f);
        sum[lane] += f * a;
      end
      wh_mem[fill_addr] = r;
      fill_addr++;
      alpha_q.push_back(alpha_width'(a));
    end
    for (int lane = 0; lane < num_feature_out; lane++) begin
      exp_q.push_back({exp_addr, expected_feature(sum[lane])});
      exp_addr++;
    end
  endtask

  task automatic wait_done();
    do begin
      @(posedge clk);
    end while (alpha_q.size() != 0 || exp_q.size() != 0 || !idle);
  endtask

  task automatic run_test(input string name, input int groups, input int max_n,
                          input int kind, input logic gaps);
    int err_before;
    int checks_before;
    @(posedge clk);
    #1;
    test_name     = name;
    err_before    = error_total();
    checks_before = checks;
    gap_mode      = gaps;
    for (int g = 0; g < groups; g++) begin
      add_group(int'($urandom_range(max_n, 1)), kind);
    end
    wait_done();
    gap_mode = 1'b0;
    tests_run++;
    $display("%s finished: %0d words checked, %0d errors",
             name, checks - checks_before, error_total() - err_before);
  endtask

  initial begin
    void'($urandom(5));
    wh_rd_data  = '0;
    alpha_dout  = '0;
    alpha_empty = 1'b1;
    gap_mode    = 1'b0;
    fill_addr   = '0;
    exp_addr    = '0;
    test_name   = "reset";
    @(posedge rst_n);
    run_test("single_row", 16, 1, 0, 1'b0);
    run_test("long_groups", 8, 20, 0, 1'b0);
    run_test("clipping", 4, 8, 1, 1'b0);
    run_test("back_pressure", 40, 2, 0, 1'b0);
    run_test("fifo_gaps", 10, 10, 0, 1'b1);
    // nothing left to do, so the design must sit still
    test_name = "idle_after_run";
    repeat (20) begin
      @(negedge clk);
      checks++;
      assert (idle && !feature_ena && !alpha_rd) else begin
        $display("idle_after_run: design busy or reading while the FIFO is empty");
        errors++;
      end
    end
    tests_run++;
    $display("idle_after_run finished");
    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, error_total());
    if (error_total() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/gat_pkg.sv
rtl/wh_stream_if.sv
rtl/wh_fetch.sv
rtl/alpha_fetch.sv
rtl/neighbor_mac.sv
rtl/feature_writer.sv
rtl/gat_aggregator.sv
test/clk_gen.sv
test/aggr_sva.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
